//--- logic/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

////////////////////////////////////////////////////////////
// data path
////////////////////////////////////////////////////////////

`define DATA_WIDTH      32      // one machine word

////////////////////////////////////////////////////////////
// register file
////////////////////////////////////////////////////////////

`define REG_ADDR_WIDTH  5       // rs, rt and rd fields
`define REG_COUNT       32      // r0 is hardwired to zero

////////////////////////////////////////////////////////////
// instruction fields
////////////////////////////////////////////////////////////

`define IMM_WIDTH       16      // i-type immediate
`define SHAMT_WIDTH     5       // r-type shift amount

`endif

//--- logic/core_pkg.sv
package core_pkg;

`include "core_defs.svh"

    typedef logic [`DATA_WIDTH-1:0]     data_t;
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_idx_t;

    // major opcode, inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,     // r-type, see funct
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111
    } opcode_e;

    // function field of OP_SPECIAL, inst[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

    // operation carried from decode to execute
    typedef enum logic [3:0] {
        ALU_NOP = 4'd0,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LU                      // pass operand b, upper immediate
    } alu_op_e;

endpackage

//--- logic/inst_decoder.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module inst_decoder (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               inst_valid,
    input  core_pkg::data_t    inst,
    output logic               dec_valid,
    output logic               dec_illegal,
    output core_pkg::alu_op_e  dec_op,
    output core_pkg::reg_idx_t dec_ra,
    output core_pkg::reg_idx_t dec_rb,
    output logic               dec_b_imm,
    output core_pkg::data_t    dec_imm,
    output core_pkg::reg_idx_t dec_rd
);
    import core_pkg::*;

    opcode_e                 op_code;
    funct_e                  funct;
    reg_idx_t                rs_field;
    reg_idx_t                rt_field;
    reg_idx_t                rd_field;
    logic [`SHAMT_WIDTH-1:0] shamt_field;
    logic [`IMM_WIDTH-1:0]   imm_field;

    data_t                   imm_sext;
    data_t                   imm_zext;
    data_t                   imm_upper;
    data_t                   shamt_zext;

    logic                    nx_writes;
    logic                    nx_illegal;
    alu_op_e                 nx_op;
    reg_idx_t                nx_ra;
    reg_idx_t                nx_rb;
    logic                    nx_b_imm;
    data_t                   nx_imm;
    reg_idx_t                nx_rd;

    assign op_code     = opcode_e'(inst[31:26]);
    assign rs_field    = inst[25:21];
    assign rt_field    = inst[20:16];
    assign rd_field    = inst[15:11];
    assign shamt_field = inst[10:6];
    assign funct       = funct_e'(inst[5:0]);
    assign imm_field   = inst[15:0];

    assign imm_sext   = {{(`DATA_WIDTH-`IMM_WIDTH){imm_field[`IMM_WIDTH-1]}}, imm_field};
    assign imm_zext   = data_t'(imm_field);
    assign imm_upper  = {imm_field, {(`DATA_WIDTH-`IMM_WIDTH){1'b0}}};    // lui
    assign shamt_zext = data_t'(shamt_field);

    ////////////////////////////////////////////////////////////
    // decode table
    ////////////////////////////////////////////////////////////

    always_comb begin
        nx_writes  = 1'b1;                      // i-type baseline
        nx_illegal = 1'b0;
        nx_op      = ALU_NOP;
        nx_ra      = rs_field;
        nx_rb      = rt_field;
        nx_b_imm   = 1'b1;
        nx_imm     = imm_sext;
        nx_rd      = rt_field;                  // i-type target is rt
        case (op_code)
            OP_SPECIAL: begin
                nx_b_imm = 1'b0;
                nx_rd    = rd_field;
                case (funct)
                    FN_SLL,  FN_SLLV: nx_op = ALU_SLL;
                    FN_SRL,  FN_SRLV: nx_op = ALU_SRL;
                    FN_SRA,  FN_SRAV: nx_op = ALU_SRA;
                    FN_ADD,  FN_ADDU: nx_op = ALU_ADD;     // no overflow trap
                    FN_SUB,  FN_SUBU: nx_op = ALU_SUB;
                    FN_AND:           nx_op = ALU_AND;
                    FN_OR:            nx_op = ALU_OR;
                    FN_XOR:           nx_op = ALU_XOR;
                    FN_NOR:           nx_op = ALU_NOR;
                    FN_SLT:           nx_op = ALU_SLT;
                    FN_SLTU:          nx_op = ALU_SLTU;
                    default: begin
                        nx_writes  = 1'b0;
                        nx_illegal = 1'b1;
                    end
                endcase
                // shift group takes the value from rt
                case (funct)
                    FN_SLL, FN_SRL, FN_SRA: begin
                        nx_ra    = rt_field;
                        nx_b_imm = 1'b1;
                        nx_imm   = shamt_zext;
                    end
                    FN_SLLV, FN_SRLV, FN_SRAV: begin
                        nx_ra = rt_field;
                        nx_rb = rs_field;       // amount register
                    end
                    default: ;
                endcase
            end
            OP_ADDI, OP_ADDIU: nx_op = ALU_ADD;
            OP_SLTI:           nx_op = ALU_SLT;
            OP_SLTIU:          nx_op = ALU_SLTU;   // sign-extended, compared unsigned
            OP_ANDI: begin
                nx_op  = ALU_AND;
                nx_imm = imm_zext;
            end
            OP_ORI: begin
                nx_op  = ALU_OR;
                nx_imm = imm_zext;
            end
            OP_XORI: begin
                nx_op  = ALU_XOR;
                nx_imm = imm_zext;
            end
            OP_LUI: begin
                nx_op  = ALU_LU;
                nx_imm = imm_upper;
            end
            default: begin
                nx_writes  = 1'b0;
                nx_illegal = 1'b1;
            end
        endcase
        if (inst == '0) begin                   // nop, would otherwise be sll r0
            nx_writes = 1'b0;
            nx_op     = ALU_NOP;
        end
    end

    ////////////////////////////////////////////////////////////
    // command register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid   <= 1'b0;
            dec_illegal <= 1'b0;
        end else begin
            dec_valid   <= inst_valid & nx_writes;
            dec_illegal <= inst_valid & nx_illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            dec_op    <= nx_op;
            dec_ra    <= nx_ra;
            dec_rb    <= nx_rb;
            dec_b_imm <= nx_b_imm;
            dec_imm   <= nx_imm;
            dec_rd    <= nx_rd;
        end
    end

endmodule

//--- logic/alu_execute.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module alu_execute (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               dec_valid,
    input  logic               dec_illegal,
    input  core_pkg::alu_op_e  dec_op,
    input  core_pkg::reg_idx_t dec_ra,
    input  core_pkg::reg_idx_t dec_rb,
    input  logic               dec_b_imm,
    input  core_pkg::data_t    dec_imm,
    input  core_pkg::reg_idx_t dec_rd,
    output core_pkg::reg_idx_t rs_idx,
    output core_pkg::reg_idx_t rt_idx,
    input  core_pkg::data_t    rs_data,
    input  core_pkg::data_t    rt_data,
    output logic               ex_valid,
    output logic               ex_illegal,
    output core_pkg::reg_idx_t ex_rd,
    output core_pkg::data_t    ex_data
);
    import core_pkg::*;

    logic                    fwd_a;
    logic                    fwd_b;
    data_t                   op_a;
    data_t                   op_b_reg;
    data_t                   op_b;
    logic [`SHAMT_WIDTH-1:0] shamt;
    data_t                   alu_result;

    ////////////////////////////////////////////////////////////
    // operand select
    ////////////////////////////////////////////////////////////

    assign rs_idx = dec_ra;                     // register file reads are combinational
    assign rt_idx = dec_rb;

    // result still in our output register, not yet in the file
    assign fwd_a = ex_valid && (ex_rd == dec_ra) && (dec_ra != '0);
    assign fwd_b = ex_valid && (ex_rd == dec_rb) && (dec_rb != '0);

    assign op_a     = fwd_a ? ex_data : rs_data;
    assign op_b_reg = fwd_b ? ex_data : rt_data;
    assign op_b     = dec_b_imm ? dec_imm : op_b_reg;
    assign shamt    = op_b[`SHAMT_WIDTH-1:0];

    ////////////////////////////////////////////////////////////
    // alu
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (dec_op)
            ALU_ADD:  alu_result = op_a + op_b;
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_AND:  alu_result = op_a & op_b;
            ALU_OR:   alu_result = op_a | op_b;
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_NOR:  alu_result = ~(op_a | op_b);
            ALU_SLT:  alu_result = data_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU: alu_result = data_t'(op_a < op_b);
            ALU_SLL:  alu_result = op_a << shamt;
            ALU_SRL:  alu_result = op_a >> shamt;
            ALU_SRA:  alu_result = $signed(op_a) >>> shamt;    // keeps sign
            ALU_LU:   alu_result = op_b;                       // already shifted up
            default:  alu_result = '0;                         // nop
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid   <= 1'b0;
            ex_illegal <= 1'b0;
        end else begin
            ex_valid   <= dec_valid;
            ex_illegal <= dec_illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            ex_rd   <= dec_rd;
            ex_data <= alu_result;
        end
    end

endmodule

//--- logic/reg_writeback.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module reg_writeback (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               ex_valid,
    input  core_pkg::reg_idx_t ex_rd,
    input  core_pkg::data_t    ex_data,
    input  core_pkg::reg_idx_t rs_idx,
    input  core_pkg::reg_idx_t rt_idx,
    output core_pkg::data_t    rs_data,
    output core_pkg::data_t    rt_data
);
    import core_pkg::*;

    data_t regs [`REG_COUNT];                   // general purpose registers

    ////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            regs <= '{default: '0};
        end else if (ex_valid && (ex_rd != '0)) begin
            regs[ex_rd] <= ex_data;             // r0 writes are dropped here
        end
    end

    ////////////////////////////////////////////////////////////
    // read ports
    ////////////////////////////////////////////////////////////

    assign rs_data = (rs_idx == '0) ? '0 : regs[rs_idx];
    assign rt_data = (rt_idx == '0) ? '0 : regs[rt_idx];

endmodule

//--- logic/alu_core.sv
`timescale 1ns/1ps

module alu_core (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               inst_valid,
    input  core_pkg::data_t    inst,
    output logic               wb_valid,
    output logic               illegal,
    output core_pkg::reg_idx_t wb_reg,
    output core_pkg::data_t    wb_data
);
    import core_pkg::*;

    // decode -> execute
    logic     dec_valid;
    logic     dec_illegal;
    alu_op_e  dec_op;
    reg_idx_t dec_ra;
    reg_idx_t dec_rb;
    logic     dec_b_imm;
    data_t    dec_imm;
    reg_idx_t dec_rd;

    // execute <-> register file
    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    data_t    rs_data;
    data_t    rt_data;
    logic     ex_valid;
    logic     ex_illegal;
    reg_idx_t ex_rd;
    data_t    ex_data;

    inst_decoder u_decoder (
        .clk         (clk),
        .arst_n      (arst_n),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .dec_valid   (dec_valid),
        .dec_illegal (dec_illegal),
        .dec_op      (dec_op),
        .dec_ra      (dec_ra),
        .dec_rb      (dec_rb),
        .dec_b_imm   (dec_b_imm),
        .dec_imm     (dec_imm),
        .dec_rd      (dec_rd)
    );

    alu_execute u_execute (
        .clk         (clk),
        .arst_n      (arst_n),
        .dec_valid   (dec_valid),
        .dec_illegal (dec_illegal),
        .dec_op      (dec_op),
        .dec_ra      (dec_ra),
        .dec_rb      (dec_rb),
        .dec_b_imm   (dec_b_imm),
        .dec_imm     (dec_imm),
        .dec_rd      (dec_rd),
        .rs_idx      (rs_idx),
        .rt_idx      (rt_idx),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .ex_valid    (ex_valid),
        .ex_illegal  (ex_illegal),
        .ex_rd       (ex_rd),
        .ex_data     (ex_data)
    );

    reg_writeback u_writeback (
        .clk      (clk),
        .arst_n   (arst_n),
        .ex_valid (ex_valid),
        .ex_rd    (ex_rd),
        .ex_data  (ex_data),
        .rs_idx   (rs_idx),
        .rt_idx   (rt_idx),
        .rs_data  (rs_data),
        .rt_data  (rt_data)
    );

    // execute results are reported as they go to the register file
    assign wb_valid = ex_valid;
    assign illegal  = ex_illegal;
    assign wb_reg   = ex_rd;
    assign wb_data  = ex_data;

endmodule

//--- bench/alu_core_assertions.sv
`timescale 1ns/1ps

module alu_core_assertions (
    input logic            clk,
    input logic            arst_n,
    input logic            inst_valid,
    input core_pkg::data_t inst,
    input logic            wb_valid,
    input logic            illegal
);

    int fail_count = 0;                     // read by the testbench at the end

    property one_kind_of_pulse;
        @(posedge clk) disable iff (!arst_n) !(wb_valid && illegal);
    endproperty

    property quiet_in_reset;
        @(posedge clk) !arst_n |-> (!wb_valid && !illegal);
    endproperty

    // a nop leaves both result flags low
    property nop_is_silent;
        @(posedge clk) disable iff (!arst_n)
            (inst_valid && inst == '0) |-> ##2 (!wb_valid && !illegal);
    endproperty

    a_one_kind: assert property (one_kind_of_pulse)
        else begin
            fail_count++;
            $error("wb_valid and illegal high in the same cycle");
        end

    a_reset_quiet: assert property (quiet_in_reset)
        else begin
            fail_count++;
            $error("result flag high during reset");
        end

    a_nop: assert property (nop_is_silent)
        else begin
            fail_count++;
            $error("nop produced a result pulse");
        end

endmodule

//--- bench/alu_core_tb.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module alu_core_tb;
    import core_pkg::*;

    typedef enum {K_NONE, K_WRITE, K_ILLEGAL} kind_e;

    localparam int TIMEOUT_CYCLES = 1000;   // 16 reset + ~600 instructions + margin

    logic     clk;
    logic     arst_n;
    logic     inst_valid;
    data_t    inst;
    logic     wb_valid;
    logic     illegal;
    reg_idx_t wb_reg;
    data_t    wb_data;

    integer   seed = 33624;
    int       cyc = 0;
    data_t    model_regs [`REG_COUNT];      // architectural state, updated at issue
    int       due_q [$];                    // cycle at which each result shows
    kind_e    kind_q [$];
    reg_idx_t reg_q [$];
    data_t    data_q [$];

    logic [5:0] arith_fns [10] = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24,
                                   6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};
    logic [5:0] shift_fns [6]  = '{6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07};
    logic [5:0] bad_fns [8]    = '{6'h01, 6'h05, 6'h08, 6'h0c, 6'h10, 6'h18, 6'h28, 6'h3f};

    alu_core dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .wb_valid   (wb_valid),
        .illegal    (illegal),
        .wb_reg     (wb_reg),
        .wb_data    (wb_data)
    );

    bind alu_core alu_core_assertions u_checks (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .wb_valid   (wb_valid),
        .illegal    (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic void predict_result(input data_t regs [`REG_COUNT], input data_t w,
                                           output kind_e kind, output reg_idx_t dest,
                                           output data_t res);
        data_t a;
        data_t b;
        data_t imm_s;
        data_t imm_z;
        a     = regs[w[25:21]];             // rs
        b     = regs[w[20:16]];             // rt
        imm_s = {{16{w[15]}}, w[15:0]};
        imm_z = {16'h0000, w[15:0]};
        kind  = K_WRITE;
        dest  = w[20:16];
        res   = '0;
        if (w == '0) begin
            kind = K_NONE;
        end else if (w[31:26] == 6'h00) begin
            dest = w[15:11];
            case (w[5:0])
                6'h00:        res = b << w[10:6];
                6'h02:        res = b >> w[10:6];
                6'h03:        res = $signed(b) >>> w[10:6];
                6'h04:        res = b << a[4:0];
                6'h06:        res = b >> a[4:0];
                6'h07:        res = $signed(b) >>> a[4:0];
                6'h20, 6'h21: res = a + b;
                6'h22, 6'h23: res = a - b;
                6'h24:        res = a & b;
                6'h25:        res = a | b;
                6'h26:        res = a ^ b;
                6'h27:        res = ~(a | b);
                6'h2a:        res = data_t'($signed(a) < $signed(b));
                6'h2b:        res = data_t'(a < b);
                default:      kind = K_ILLEGAL;
            endcase
        end else begin
            case (w[31:26])
                6'h08, 6'h09: res = a + imm_s;
                6'h0a:        res = data_t'($signed(a) < $signed(imm_s));
                6'h0b:        res = data_t'(a < imm_s);
                6'h0c:        res = a & imm_z;
                6'h0d:        res = a | imm_z;
                6'h0e:        res = a ^ imm_z;
                6'h0f:        res = {w[15:0], 16'h0000};
                default:      kind = K_ILLEGAL;
            endcase
        end
    endfunction

    function automatic data_t r_word(input logic [5:0] fn, input reg_idx_t rs,
                                     input reg_idx_t rt, input reg_idx_t rd,
                                     input logic [4:0] sh);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic data_t i_word(input logic [5:0] op, input reg_idx_t rs,
                                     input reg_idx_t rt, input data_t imm);
        return {op, rs, rt, imm[15:0]};
    endfunction

    function automatic data_t rand_word();
        return $random(seed);
    endfunction

    function automatic reg_idx_t rand_reg();
        return reg_idx_t'(rand_word());
    endfunction

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Finished with errors");
        $fatal(1, "run stopped");
    endtask

    task automatic check_wb(input reg_idx_t exp_reg, input data_t exp_data);
        if (wb_valid !== 1'b1 || illegal !== 1'b0)
            stop_on_error($sformatf("ERR %0t: no write reported, expected r%0d = %h",
                                    $time, exp_reg, exp_data));
        else if (wb_reg !== exp_reg || wb_data !== exp_data)
            stop_on_error($sformatf("ERR %0t: wrote r%0d = %h, expected r%0d = %h",
                                    $time, wb_reg, wb_data, exp_reg, exp_data));
    endtask

    task automatic check_illegal(input logic exp_illegal);
        if (illegal !== exp_illegal)
            stop_on_error($sformatf("ERR %0t: illegal is %b, expected %b",
                                    $time, illegal, exp_illegal));
        else if (wb_valid !== 1'b0)
            stop_on_error($sformatf("unexpected register write to r%0d at time %0t",
                                    wb_reg, $time));
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc == TIMEOUT_CYCLES)
            stop_on_error($sformatf("timeout, the run did not end within %0d cycles",
                                    TIMEOUT_CYCLES));
    end

    always @(negedge clk) begin : compare
        kind_e    kind;
        reg_idx_t dest;
        data_t    res;
        if (due_q.size() != 0 && due_q[0] == cyc) begin
            void'(due_q.pop_front());
            kind = kind_q.pop_front();
            dest = reg_q.pop_front();
            res  = data_q.pop_front();
            case (kind)
                K_WRITE:   check_wb(dest, res);
                K_ILLEGAL: check_illegal(1'b1);
                default:   check_illegal(1'b0);     // nop
            endcase
        end else begin
            check_illegal(1'b0);                    // idle slot, nothing may pulse
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    task automatic send_inst(input data_t w);
        kind_e    kind;
        reg_idx_t dest;
        data_t    res;
        predict_result(model_regs, w, kind, dest, res);
        if (kind == K_WRITE && dest != '0)
            model_regs[dest] = res;
        @(posedge clk);
        inst_valid <= 1'b1;
        inst       <= w;
        due_q.push_back(cyc + 3);               // sampled next edge, reported one later
        kind_q.push_back(kind);
        reg_q.push_back(dest);
        data_q.push_back(res);
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        inst_valid <= 1'b0;
        inst       <= rand_word();              // junk, ignored without inst_valid
    endtask

    task automatic maybe_gap();
        if ((rand_word() & 7) == 0)
            idle_cycle();
    endtask

    initial begin
        int       i;
        data_t    v;
        reg_idx_t rd;
        reg_idx_t last_rd;
        arst_n     = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        model_regs = '{default: '0};
        #1 arst_n = 1'b0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        repeat (2) idle_cycle();

        send_inst(r_word(6'h21, 5'd1, 5'd2, 5'd3, 5'd0));   // addu from cleared regs
        for (i = 1; i < `REG_COUNT; i++) begin
            v = rand_word();
            send_inst(i_word(6'h0f, 5'd0, reg_idx_t'(i), v >> 16));
            send_inst(i_word(6'h0d, reg_idx_t'(i), reg_idx_t'(i), v));
        end

        for (i = 0; i < 128; i++) begin         // addi .. lui
            send_inst(i_word(6'(8 + i % 8), rand_reg(), rand_reg(), rand_word()));
            maybe_gap();
        end

        last_rd = 5'd1;
        for (i = 0; i < 200; i++) begin         // dependent chains, forwarding
            v  = rand_word();
            rd = rand_reg();
            send_inst(r_word(arith_fns[v[7:4] % 10], v[0] ? last_rd : rand_reg(),
                             v[1] ? last_rd : rand_reg(), rd, 5'd0));
            last_rd = rd;
        end

        send_inst(i_word(6'h0f, 5'd0, 5'd5, 32'h8000));     // r5 negative
        send_inst(r_word(6'h03, 5'd0, 5'd5, 5'd6, 5'd7));
        for (i = 0; i < 96; i++) begin
            v = rand_word();
            send_inst(r_word(shift_fns[i % 6], rand_reg(), rand_reg(), rand_reg(), v[4:0]));
            maybe_gap();
        end

        send_inst('0);
        idle_cycle();
        send_inst('0);
        send_inst(i_word(6'h09, 5'd7, 5'd0, 32'h1234));     // addiu into r0
        send_inst(r_word(6'h25, 5'd0, 5'd0, 5'd9, 5'd0));   // r0 read right after
        send_inst(r_word(6'h21, 5'd0, 5'd11, 5'd10, 5'd0));

        for (i = 0; i < 40; i++) begin
            v = rand_word();
            if (i % 2)
                send_inst({1'b1, v[30:0]});     // opcodes 0x20 and up
            else
                send_inst(r_word(bad_fns[v[2:0]], v[25:21], v[20:16], v[15:11], v[10:6]));
        end
        for (i = 1; i < `REG_COUNT; i++)
            send_inst(r_word(6'h21, reg_idx_t'(i), 5'd0, reg_idx_t'(i), 5'd0));

        idle_cycle();
        while (due_q.size() != 0)
            idle_cycle();
        repeat (2) idle_cycle();
        if (dut.u_checks.fail_count != 0) begin
            $display("Finished with errors");
            $fatal(1, "assertion failures seen");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

//--- alu_core.f
+incdir+logic
logic/core_pkg.sv
logic/inst_decoder.sv
logic/alu_execute.sv
logic/reg_writeback.sv
logic/alu_core.sv
bench/alu_core_assertions.sv
bench/alu_core_tb.sv
